/* Makefile */
# Verilator build and run for the key/value table testbench

SOURCES := $(shell cat project.f)

all: run

obj_dir/Vdb_top_tb: project.f $(SOURCES)
	verilator --binary --timing --assert --top-module db_top_tb -f project.f

run: obj_dir/Vdb_top_tb
	./obj_dir/Vdb_top_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* project.f */
src/db_cmd_pkg.sv
src/db_cfg_pkg.sv
src/db_req_stage.sv
src/db_prio_arbiter.sv
src/db_kv_store.sv
src/db_top.sv
test/db_top_properties.sv
test/db_top_tb.sv

/* src/db_cfg_pkg.sv */
`default_nettype none

package db_cfg_pkg;

    // Table geometry
    localparam int KEY_WID     = 4;
    localparam int VALUE_WID   = 8;
    localparam int NUM_ENTRIES = 2**KEY_WID;

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;

endpackage : db_cfg_pkg

`default_nettype wire

/* src/db_cmd_pkg.sv */
`default_nettype none

package db_cmd_pkg;

    // Commands understood by the key/value table
    typedef enum logic [2:0] {
        COMMAND_NOP   = 3'd0,
        COMMAND_GET   = 3'd1,
        COMMAND_SET   = 3'd2,
        COMMAND_UNSET = 3'd3,
        COMMAND_CLEAR = 3'd4
    } command_t;

    // Response status
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_UNSPECIFIED = 2'd2
    } status_t;

endpackage : db_cmd_pkg

`default_nettype wire

/* src/db_kv_store.sv */
`timescale 1ns/100ps
`default_nettype none

module db_kv_store (
    input  wire logic                 clk,
    input  wire logic                 srst,
    input  wire logic                 i_req,
    input  wire db_cmd_pkg::command_t i_command,
    input  wire db_cfg_pkg::key_t     i_key,
    input  wire db_cfg_pkg::value_t   i_value,
    output logic                      o_rdy,
    output logic                      o_ack,
    output db_cmd_pkg::status_t       o_status,
    output logic                      o_get_valid,
    output db_cfg_pkg::value_t        o_get_value
);

    db_cfg_pkg::value_t                 mem [db_cfg_pkg::NUM_ENTRIES];
    logic [db_cfg_pkg::NUM_ENTRIES-1:0] valid;
    logic                               busy;
    logic                               clearing;
    db_cfg_pkg::key_t                   clr_cnt;
    logic                               xfer;
    logic                               clr_last;

    assign o_rdy    = !busy;
    assign xfer     = i_req && o_rdy;
    assign clr_last = (clr_cnt == db_cfg_pkg::key_t'(db_cfg_pkg::NUM_ENTRIES - 1));

    // Busy from transfer through the ack cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            busy     <= 1'b0;
            clearing <= 1'b0;
            clr_cnt  <= '0;
            o_ack    <= 1'b0;
        end else begin
            o_ack <= 1'b0;
            if (xfer) begin
                busy <= 1'b1;
                if (i_command == db_cmd_pkg::COMMAND_CLEAR) begin
                    clearing <= 1'b1;
                    clr_cnt  <= '0;
                end else begin
                    o_ack <= 1'b1;
                end
            end else if (clearing) begin
                // One entry per cycle
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_last) begin
                    clearing <= 1'b0;
                    o_ack    <= 1'b1;
                end
            end else if (o_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            valid <= '0;
        end else if (xfer) begin
            if (i_command == db_cmd_pkg::COMMAND_SET) begin
                valid[i_key] <= 1'b1;
            end else if (i_command == db_cmd_pkg::COMMAND_UNSET) begin
                valid[i_key] <= 1'b0;
            end
        end else if (clearing) begin
            valid[clr_cnt] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && i_command == db_cmd_pkg::COMMAND_SET) begin
            mem[i_key] <= i_value;
        end
    end

    // Response captured at transfer, held until the ack
    always_ff @(posedge clk) begin
        if (xfer) begin
            o_status    <= db_cmd_pkg::STATUS_OK;
            o_get_valid <= 1'b0;
            o_get_value <= '0;
            case (i_command)
                db_cmd_pkg::COMMAND_GET: begin
                    o_get_valid <= valid[i_key];
                    o_get_value <= valid[i_key] ? mem[i_key] : '0;
                end
                db_cmd_pkg::COMMAND_NOP,
                db_cmd_pkg::COMMAND_SET,
                db_cmd_pkg::COMMAND_UNSET,
                db_cmd_pkg::COMMAND_CLEAR: ;
                default: o_status <= db_cmd_pkg::STATUS_ERROR;
            endcase
        end
    end

endmodule : db_kv_store

`default_nettype wire

/* src/db_prio_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module db_prio_arbiter (
    input  wire logic                 clk,
    input  wire logic                 srst,
    // High-priority side
    input  wire logic                 i_hi_req,
    input  wire db_cmd_pkg::command_t i_hi_command,
    input  wire db_cfg_pkg::key_t     i_hi_key,
    input  wire db_cfg_pkg::value_t   i_hi_value,
    output logic                      o_hi_rdy,
    output logic                      o_hi_ack,
    output db_cmd_pkg::status_t       o_hi_status,
    output logic                      o_hi_get_valid,
    output db_cfg_pkg::value_t        o_hi_get_value,
    // Low-priority side
    input  wire logic                 i_lo_req,
    input  wire db_cmd_pkg::command_t i_lo_command,
    input  wire db_cfg_pkg::key_t     i_lo_key,
    input  wire db_cfg_pkg::value_t   i_lo_value,
    output logic                      o_lo_rdy,
    output logic                      o_lo_ack,
    output db_cmd_pkg::status_t       o_lo_status,
    output logic                      o_lo_get_valid,
    output db_cfg_pkg::value_t        o_lo_get_value,
    // Shared table
    output logic                      o_tbl_req,
    output db_cmd_pkg::command_t      o_tbl_command,
    output db_cfg_pkg::key_t          o_tbl_key,
    output db_cfg_pkg::value_t        o_tbl_value,
    input  wire logic                 i_tbl_rdy,
    input  wire logic                 i_tbl_ack,
    input  wire db_cmd_pkg::status_t  i_tbl_status,
    input  wire logic                 i_tbl_get_valid,
    input  wire db_cfg_pkg::value_t   i_tbl_get_value
);

    logic                 owner_hi;
    db_cmd_pkg::status_t  rsp_status;
    logic                 rsp_get_valid;
    db_cfg_pkg::value_t   rsp_get_value;

    // Strict priority, hi wins whenever it asks
    assign o_tbl_req     = i_hi_req || i_lo_req;
    assign o_tbl_command = i_hi_req ? i_hi_command : i_lo_command;
    assign o_tbl_key     = i_hi_req ? i_hi_key : i_lo_key;
    assign o_tbl_value   = i_hi_req ? i_hi_value : i_lo_value;

    assign o_hi_rdy = i_tbl_rdy;
    assign o_lo_rdy = i_tbl_rdy && !i_hi_req;

    // Remember who owns the table transaction
    always_ff @(posedge clk) begin
        if (srst) begin
            owner_hi <= 1'b0;
        end else if (o_tbl_req && i_tbl_rdy) begin
            owner_hi <= i_hi_req;
        end
    end

    // Ack is steered with the owner seen in the table's ack cycle,
    // so a grant in that same cycle cannot misroute it
    always_ff @(posedge clk) begin
        if (srst) begin
            o_hi_ack <= 1'b0;
            o_lo_ack <= 1'b0;
        end else begin
            o_hi_ack <= i_tbl_ack && owner_hi;
            o_lo_ack <= i_tbl_ack && !owner_hi;
        end
    end

    always_ff @(posedge clk) begin
        rsp_status    <= i_tbl_status;
        rsp_get_valid <= i_tbl_get_valid;
        rsp_get_value <= i_tbl_get_value;
    end

    // Non-owner sees no status
    assign o_hi_status    = o_hi_ack ? rsp_status : db_cmd_pkg::STATUS_UNSPECIFIED;
    assign o_lo_status    = o_lo_ack ? rsp_status : db_cmd_pkg::STATUS_UNSPECIFIED;
    assign o_hi_get_valid = o_hi_ack && rsp_get_valid;
    assign o_lo_get_valid = o_lo_ack && rsp_get_valid;
    assign o_hi_get_value = rsp_get_value;
    assign o_lo_get_value = rsp_get_value;

endmodule : db_prio_arbiter

`default_nettype wire

/* src/db_req_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module db_req_stage (
    input  wire logic                 clk,
    input  wire logic                 srst,
    // Upstream requester
    input  wire logic                 i_req,
    input  wire db_cmd_pkg::command_t i_command,
    input  wire db_cfg_pkg::key_t     i_key,
    input  wire db_cfg_pkg::value_t   i_value,
    output logic                      o_rdy,
    output logic                      o_ack,
    output db_cmd_pkg::status_t       o_status,
    output logic                      o_get_valid,
    output db_cfg_pkg::value_t        o_get_value,
    // Downstream responder
    output logic                      o_down_req,
    output db_cmd_pkg::command_t      o_down_command,
    output db_cfg_pkg::key_t          o_down_key,
    output db_cfg_pkg::value_t        o_down_value,
    input  wire logic                 i_down_rdy,
    input  wire logic                 i_down_ack,
    input  wire db_cmd_pkg::status_t  i_down_status,
    input  wire logic                 i_down_get_valid,
    input  wire db_cfg_pkg::value_t   i_down_get_value
);

    logic pending;
    logic in_progress;

    // Command accepted but not yet handed downstream
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (i_req && o_rdy) begin
            pending <= 1'b1;
        end else if (pending && i_down_rdy) begin
            pending <= 1'b0;
        end
    end

    // Handed downstream, waiting for the ack
    always_ff @(posedge clk) begin
        if (srst) begin
            in_progress <= 1'b0;
        end else if (pending && i_down_rdy) begin
            in_progress <= 1'b1;
        end else if (i_down_ack) begin
            in_progress <= 1'b0;
        end
    end

    assign o_rdy      = !pending && !in_progress;
    assign o_down_req = pending;

    // Hold the command context for the downstream side
    always_ff @(posedge clk) begin
        if (i_req && o_rdy) begin
            o_down_command <= i_command;
            o_down_key     <= i_key;
            o_down_value   <= i_value;
        end
    end

    // Response goes straight back
    assign o_ack       = i_down_ack;
    assign o_status    = i_down_status;
    assign o_get_valid = i_down_get_valid;
    assign o_get_value = i_down_get_value;

endmodule : db_req_stage

`default_nettype wire

/* src/db_top.sv */
`timescale 1ns/100ps
`default_nettype none

module db_top (
    input  wire logic                 clk,
    input  wire logic                 srst,
    input  wire logic                 i_hi_req,
    input  wire db_cmd_pkg::command_t i_hi_command,
    input  wire db_cfg_pkg::key_t     i_hi_key,
    input  wire db_cfg_pkg::value_t   i_hi_value,
    output logic                      o_hi_rdy,
    output logic                      o_hi_ack,
    output db_cmd_pkg::status_t       o_hi_status,
    output logic                      o_hi_get_valid,
    output db_cfg_pkg::value_t        o_hi_get_value,
    input  wire logic                 i_lo_req,
    input  wire db_cmd_pkg::command_t i_lo_command,
    input  wire db_cfg_pkg::key_t     i_lo_key,
    input  wire db_cfg_pkg::value_t   i_lo_value,
    output logic                      o_lo_rdy,
    output logic                      o_lo_ack,
    output db_cmd_pkg::status_t       o_lo_status,
    output logic                      o_lo_get_valid,
    output db_cfg_pkg::value_t        o_lo_get_value
);

    // Stage to arbiter, hi side
    logic                 hi_req, hi_rdy, hi_ack, hi_get_valid;
    db_cmd_pkg::command_t hi_command;
    db_cfg_pkg::key_t     hi_key;
    db_cfg_pkg::value_t   hi_value, hi_get_value;
    db_cmd_pkg::status_t  hi_status;

    // Stage to arbiter, lo side
    logic                 lo_req, lo_rdy, lo_ack, lo_get_valid;
    db_cmd_pkg::command_t lo_command;
    db_cfg_pkg::key_t     lo_key;
    db_cfg_pkg::value_t   lo_value, lo_get_value;
    db_cmd_pkg::status_t  lo_status;

    // Arbiter to table
    logic                 tbl_req, tbl_rdy, tbl_ack, tbl_get_valid;
    db_cmd_pkg::command_t tbl_command;
    db_cfg_pkg::key_t     tbl_key;
    db_cfg_pkg::value_t   tbl_value, tbl_get_value;
    db_cmd_pkg::status_t  tbl_status;

    db_req_stage u_hi_stage (
        .clk              (clk),
        .srst             (srst),
        .i_req            (i_hi_req),
        .i_command        (i_hi_command),
        .i_key            (i_hi_key),
        .i_value          (i_hi_value),
        .o_rdy            (o_hi_rdy),
        .o_ack            (o_hi_ack),
        .o_status         (o_hi_status),
        .o_get_valid      (o_hi_get_valid),
        .o_get_value      (o_hi_get_value),
        .o_down_req       (hi_req),
        .o_down_command   (hi_command),
        .o_down_key       (hi_key),
        .o_down_value     (hi_value),
        .i_down_rdy       (hi_rdy),
        .i_down_ack       (hi_ack),
        .i_down_status    (hi_status),
        .i_down_get_valid (hi_get_valid),
        .i_down_get_value (hi_get_value)
    );

    db_req_stage u_lo_stage (
        .clk              (clk),
        .srst             (srst),
        .i_req            (i_lo_req),
        .i_command        (i_lo_command),
        .i_key            (i_lo_key),
        .i_value          (i_lo_value),
        .o_rdy            (o_lo_rdy),
        .o_ack            (o_lo_ack),
        .o_status         (o_lo_status),
        .o_get_valid      (o_lo_get_valid),
        .o_get_value      (o_lo_get_value),
        .o_down_req       (lo_req),
        .o_down_command   (lo_command),
        .o_down_key       (lo_key),
        .o_down_value     (lo_value),
        .i_down_rdy       (lo_rdy),
        .i_down_ack       (lo_ack),
        .i_down_status    (lo_status),
        .i_down_get_valid (lo_get_valid),
        .i_down_get_value (lo_get_value)
    );

    db_prio_arbiter u_arbiter (
        .clk             (clk),
        .srst            (srst),
        .i_hi_req        (hi_req),
        .i_hi_command    (hi_command),
        .i_hi_key        (hi_key),
        .i_hi_value      (hi_value),
        .o_hi_rdy        (hi_rdy),
        .o_hi_ack        (hi_ack),
        .o_hi_status     (hi_status),
        .o_hi_get_valid  (hi_get_valid),
        .o_hi_get_value  (hi_get_value),
        .i_lo_req        (lo_req),
        .i_lo_command    (lo_command),
        .i_lo_key        (lo_key),
        .i_lo_value      (lo_value),
        .o_lo_rdy        (lo_rdy),
        .o_lo_ack        (lo_ack),
        .o_lo_status     (lo_status),
        .o_lo_get_valid  (lo_get_valid),
        .o_lo_get_value  (lo_get_value),
        .o_tbl_req       (tbl_req),
        .o_tbl_command   (tbl_command),
        .o_tbl_key       (tbl_key),
        .o_tbl_value     (tbl_value),
        .i_tbl_rdy       (tbl_rdy),
        .i_tbl_ack       (tbl_ack),
        .i_tbl_status    (tbl_status),
        .i_tbl_get_valid (tbl_get_valid),
        .i_tbl_get_value (tbl_get_value)
    );

    db_kv_store u_kv_store (
        .clk         (clk),
        .srst        (srst),
        .i_req       (tbl_req),
        .i_command   (tbl_command),
        .i_key       (tbl_key),
        .i_value     (tbl_value),
        .o_rdy       (tbl_rdy),
        .o_ack       (tbl_ack),
        .o_status    (tbl_status),
        .o_get_valid (tbl_get_valid),
        .o_get_value (tbl_get_value)
    );

endmodule : db_top

`default_nettype wire

/* test/db_top_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module db_top_properties (
    input wire logic clk,
    input wire logic srst,
    input wire logic i_hi_req,
    input wire logic o_hi_rdy,
    input wire logic o_hi_ack,
    input wire logic i_lo_req,
    input wire logic o_lo_rdy,
    input wire logic o_lo_ack
);

    logic hi_open;
    logic lo_open;

    // A side is open from its transfer until its ack
    always_ff @(posedge clk) begin
        if (srst) begin
            hi_open <= 1'b0;
            lo_open <= 1'b0;
        end else begin
            if (i_hi_req && o_hi_rdy) begin
                hi_open <= 1'b1;
            end else if (o_hi_ack) begin
                hi_open <= 1'b0;
            end
            if (i_lo_req && o_lo_rdy) begin
                lo_open <= 1'b1;
            end else if (o_lo_ack) begin
                lo_open <= 1'b0;
            end
        end
    end

    hi_ack_needs_transfer: assert property (@(posedge clk) disable iff (srst)
        o_hi_ack |-> hi_open)
        else $error("o_hi_ack high with no transfer on the hi side");
    lo_ack_needs_transfer: assert property (@(posedge clk) disable iff (srst)
        o_lo_ack |-> lo_open)
        else $error("o_lo_ack high with no transfer on the lo side");

    // No second command accepted before the ack
    hi_rdy_low_while_open: assert property (@(posedge clk) disable iff (srst)
        hi_open |-> !o_hi_rdy)
        else $error("o_hi_rdy high between transfer and ack");
    lo_rdy_low_while_open: assert property (@(posedge clk) disable iff (srst)
        lo_open |-> !o_lo_rdy)
        else $error("o_lo_rdy high between transfer and ack");

    hi_ack_one_cycle: assert property (@(posedge clk) disable iff (srst)
        o_hi_ack |=> !o_hi_ack)
        else $error("o_hi_ack held for more than one cycle");
    lo_ack_one_cycle: assert property (@(posedge clk) disable iff (srst)
        o_lo_ack |=> !o_lo_ack)
        else $error("o_lo_ack held for more than one cycle");

endmodule : db_top_properties

bind db_top db_top_properties u_props (
    .clk      (clk),
    .srst     (srst),
    .i_hi_req (i_hi_req),
    .o_hi_rdy (o_hi_rdy),
    .o_hi_ack (o_hi_ack),
    .i_lo_req (i_lo_req),
    .o_lo_rdy (o_lo_rdy),
    .o_lo_ack (o_lo_ack)
);

`default_nettype wire

/* test/db_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module db_top_tb;

    logic                 clk;
    logic                 srst;
    logic                 hi_req;
    db_cmd_pkg::command_t hi_command;
    db_cfg_pkg::key_t     hi_key;
    db_cfg_pkg::value_t   hi_value;
    logic                 lo_req;
    db_cmd_pkg::command_t lo_command;
    db_cfg_pkg::key_t     lo_key;
    db_cfg_pkg::value_t   lo_value;
    wire logic            hi_rdy, hi_ack, hi_get_valid;
    wire logic            lo_rdy, lo_ack, lo_get_valid;
    db_cmd_pkg::status_t  hi_status, lo_status;
    db_cfg_pkg::value_t   hi_get_value, lo_get_value;

    // Reference table and the open transaction of each side (0 is hi, 1 is lo)
    db_cfg_pkg::value_t                 model_value [db_cfg_pkg::NUM_ENTRIES];
    logic [db_cfg_pkg::NUM_ENTRIES-1:0] model_valid;
    db_cmd_pkg::command_t               open_command [2];
    db_cfg_pkg::key_t                   open_key [2];
    db_cfg_pkg::value_t                 open_value [2];
    time                                ack_time [2];
    integer                             seed;
    int                                 wait_limit;

    db_top u_dut (
        .clk            (clk),
        .srst           (srst),
        .i_hi_req       (hi_req),
        .i_hi_command   (hi_command),
        .i_hi_key       (hi_key),
        .i_hi_value     (hi_value),
        .o_hi_rdy       (hi_rdy),
        .o_hi_ack       (hi_ack),
        .o_hi_status    (hi_status),
        .o_hi_get_valid (hi_get_valid),
        .o_hi_get_value (hi_get_value),
        .i_lo_req       (lo_req),
        .i_lo_command   (lo_command),
        .i_lo_key       (lo_key),
        .i_lo_value     (lo_value),
        .o_lo_rdy       (lo_rdy),
        .o_lo_ack       (lo_ack),
        .o_lo_status    (lo_status),
        .o_lo_get_valid (lo_get_valid),
        .o_lo_get_value (lo_get_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic drive_side(input bit is_lo, input logic req, input db_cmd_pkg::command_t cmd,
                              input db_cfg_pkg::key_t key, input db_cfg_pkg::value_t value);
        if (is_lo) begin
            lo_req     <= req;
            lo_command <= cmd;
            lo_key     <= key;
            lo_value   <= value;
        end else begin
            hi_req     <= req;
            hi_command <= cmd;
            hi_key     <= key;
            hi_value   <= value;
        end
    endtask

    task automatic send_command(input bit is_lo, input db_cmd_pkg::command_t cmd,
                                input db_cfg_pkg::key_t key, input db_cfg_pkg::value_t value);
        int waited;
        waited = 0;
        @(posedge clk);
        drive_side(is_lo, 1'b1, cmd, key, value);
        @(negedge clk);
        // Transfer on the first edge that finds rdy high
        while (!(is_lo ? lo_rdy : hi_rdy)) begin
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for rdy on the %s side", is_lo ? "lo" : "hi");
                stop_with_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        drive_side(is_lo, 1'b0, cmd, key, value);
        open_command[is_lo] = cmd;
        open_key[is_lo]     = key;
        open_value[is_lo]   = value;
    endtask

    task automatic check_response(input bit is_lo);
        db_cmd_pkg::command_t cmd;
        db_cfg_pkg::key_t     key;
        db_cmd_pkg::status_t  exp_status;
        logic                 exp_valid;
        db_cfg_pkg::value_t   exp_value;
        string                side;
        cmd        = open_command[is_lo];
        key        = open_key[is_lo];
        side       = is_lo ? "lo" : "hi";
        exp_status = db_cmd_pkg::STATUS_OK;
        exp_valid  = 1'b0;
        exp_value  = '0;
        // Acks arrive in the order the table ran the commands
        case (cmd)
            db_cmd_pkg::COMMAND_NOP: ;
            db_cmd_pkg::COMMAND_GET: begin
                exp_valid = model_valid[key];
                exp_value = model_value[key];
            end
            db_cmd_pkg::COMMAND_SET: begin
                model_valid[key] = 1'b1;
                model_value[key] = open_value[is_lo];
            end
            db_cmd_pkg::COMMAND_UNSET: model_valid[key] = 1'b0;
            db_cmd_pkg::COMMAND_CLEAR: model_valid = '0;
            default: exp_status = db_cmd_pkg::STATUS_ERROR;
        endcase
        assert ((is_lo ? lo_status : hi_status) == exp_status) else begin
            $display("ERR o_%s_status: got %h, expected %h", side,
                     is_lo ? lo_status : hi_status, exp_status);
            stop_with_failure();
        end
        assert ((is_lo ? lo_get_valid : hi_get_valid) == exp_valid) else begin
            $display("ERR o_%s_get_valid: got %h, expected %h", side,
                     is_lo ? lo_get_valid : hi_get_valid, exp_valid);
            stop_with_failure();
        end
        // Value only matters on a hit
        assert (!exp_valid || (is_lo ? lo_get_value : hi_get_value) == exp_value) else begin
            $display("ERR o_%s_get_value: got %h, expected %h", side,
                     is_lo ? lo_get_value : hi_get_value, exp_value);
            stop_with_failure();
        end
    endtask

    task automatic await_response(input bit is_lo);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(is_lo ? lo_ack : hi_ack)) begin
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for ack on the %s side", is_lo ? "lo" : "hi");
                stop_with_failure();
            end
            @(negedge clk);
        end
        ack_time[is_lo] = $time;
        check_response(is_lo);
    endtask

    task automatic do_transaction(input bit is_lo, input db_cmd_pkg::command_t cmd,
                                  input db_cfg_pkg::key_t key, input db_cfg_pkg::value_t value);
        send_command(is_lo, cmd, key, value);
        await_response(is_lo);
    endtask

    initial begin
        db_cfg_pkg::key_t   key;
        db_cfg_pkg::value_t value;
        db_cfg_pkg::key_t   used_keys [4];
        int                 waited;
        seed        = 32'hf1b33983;
        wait_limit  = 100;
        model_valid = '0;
        srst        = 1'b1;
        hi_req      = 1'b0;
        hi_command  = db_cmd_pkg::COMMAND_NOP;
        hi_key      = '0;
        hi_value    = '0;
        lo_req      = 1'b0;
        lo_command  = db_cmd_pkg::COMMAND_NOP;
        lo_key      = '0;
        lo_value    = '0;
        repeat (16) @(posedge clk);
        srst <= 1'b0;

        // Quiet outputs, then both sides ready
        @(negedge clk);
        assert (!hi_ack && !lo_ack) else begin
            $display("ERR o_hi_ack/o_lo_ack after reset: got %h/%h, expected 0/0", hi_ack, lo_ack);
            stop_with_failure();
        end
        waited = 0;
        while (!(hi_rdy && lo_rdy)) begin
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for both rdy outputs to rise after reset");
                stop_with_failure();
            end
            @(negedge clk);
        end

        // Miss on an empty table, and a NOP
        do_transaction(0, db_cmd_pkg::COMMAND_GET, db_cfg_pkg::key_t'($random(seed)), '0);
        do_transaction(1, db_cmd_pkg::COMMAND_NOP, '0, '0);

        for (int i = 0; i < 4; i++) begin
            used_keys[i] = db_cfg_pkg::key_t'($random(seed));
            value        = db_cfg_pkg::value_t'($random(seed));
            do_transaction(i[0], db_cmd_pkg::COMMAND_SET, used_keys[i], value);
            do_transaction(!i[0], db_cmd_pkg::COMMAND_GET, used_keys[i], '0);
        end

        do_transaction(1, db_cmd_pkg::COMMAND_UNSET, used_keys[3], '0);
        do_transaction(0, db_cmd_pkg::COMMAND_GET, used_keys[3], '0);

        do_transaction(1, db_cmd_pkg::COMMAND_CLEAR, '0, '0);
        for (int i = 0; i < 3; i++) begin
            do_transaction(i[0], db_cmd_pkg::COMMAND_GET, used_keys[i], '0);
        end

        // Same-cycle transfer on both sides, hi must finish first
        key   = db_cfg_pkg::key_t'($random(seed));
        value = db_cfg_pkg::value_t'($random(seed));
        fork
            do_transaction(0, db_cmd_pkg::COMMAND_SET, key, value);
            do_transaction(1, db_cmd_pkg::COMMAND_GET, key, '0);
        join
        assert (ack_time[0] < ack_time[1]) else begin
            $display("The lo side was acknowledged before the hi side after a same-cycle transfer");
            stop_with_failure();
        end

        // lo SET lands while a hi CLEAR walks the table
        value = db_cfg_pkg::value_t'($random(seed));
        fork
            begin
                do_transaction(0, db_cmd_pkg::COMMAND_CLEAR, '0, '0);
                do_transaction(0, db_cmd_pkg::COMMAND_GET, key, '0);
            end
            begin
                repeat (4) @(posedge clk);
                do_transaction(1, db_cmd_pkg::COMMAND_SET, key, value);
            end
        join

        // Illegal codes leave the entry alone
        do_transaction(1, db_cmd_pkg::COMMAND_SET, key, ~value);
        do_transaction(0, db_cmd_pkg::command_t'(3'd5), key, value);
        do_transaction(1, db_cmd_pkg::command_t'(3'd7), key, value);
        do_transaction(0, db_cmd_pkg::COMMAND_GET, key, '0);

        $display("TEST OK");
        $finish;
    end

endmodule : db_top_tb

`default_nettype wire
